// ==== rtl/axi_guard_defs.svh ====
/* Outstanding-request limits of the AXI4 memory port guard.
   Included by the tracker and the testbench */

`ifndef AXI_GUARD_DEFS_SVH
`define AXI_GUARD_DEFS_SVH

////////////////////
// Write direction
////////////////////

// Writes allowed in flight before AW is held off
`define AXI_GUARD_MAX_WR_OR 8

////////////////////
// Read direction
////////////////////

// Reads allowed in flight before AR is held off
`define AXI_GUARD_MAX_RD_OR 8

`endif

// ==== rtl/axi_guard_pkg.sv ====
/* Types shared by the AXI4 guard modules and its testbench.
   Only the handshake bits of the five channels are carried */

`default_nettype none

package axi_guard_pkg;

    // Bits driven by the AXI master
    typedef struct packed {
        logic awvalid;
        logic arvalid;
        logic bready;
        logic rready;
    } axi_mst_t;

    // Bits driven by the AXI slave
    typedef struct packed {
        logic awready;
        logic arready;
        logic bvalid;
        logic rvalid;
    } axi_slv_t;

    // Tracker flags, all levels
    typedef struct packed {
        logic wr_pending;
        logic rd_pending;
        logic wr_full;
        logic rd_full;
    } or_status_t;

    // Fence sequence
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        DRAIN = 2'd1,
        DONE  = 2'd2
    } fence_state_t;

endpackage

`default_nettype wire

// ==== rtl/axi_or_tracker.sv ====
/* Counts write and read requests waiting for a completion on the memory side.
   Flags come from the registered counts, one cycle after the handshakes */

`timescale 1ns/1ps
`default_nettype none

`include "axi_guard_defs.svh"

module axi_or_tracker
    import axi_guard_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       aresetn,
    input  wire logic       srst,
    input  wire axi_mst_t   mem_mst,
    input  wire axi_slv_t   mem_slv,
    output or_status_t      or_status
);

    // Wide enough to hold the limit itself
    localparam int WR_CNT_W = $clog2(`AXI_GUARD_MAX_WR_OR + 1);
    localparam int RD_CNT_W = $clog2(`AXI_GUARD_MAX_RD_OR + 1);

    localparam logic [WR_CNT_W-1:0] WR_MAX = WR_CNT_W'(`AXI_GUARD_MAX_WR_OR);
    localparam logic [RD_CNT_W-1:0] RD_MAX = RD_CNT_W'(`AXI_GUARD_MAX_RD_OR);

    logic                wr_accept;
    logic                wr_cpl;
    logic                rd_accept;
    logic                rd_cpl;
    logic [WR_CNT_W-1:0] wr_count;
    logic [RD_CNT_W-1:0] rd_count;

    ////////////////////
    // Handshakes
    ////////////////////

    assign wr_accept = mem_mst.awvalid & mem_slv.awready;
    assign wr_cpl    = mem_slv.bvalid & mem_mst.bready;
    assign rd_accept = mem_mst.arvalid & mem_slv.arready;
    assign rd_cpl    = mem_slv.rvalid & mem_mst.rready;

    ////////////////////
    // Counters
    ////////////////////

    // Accept and completion together cancel out
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_count <= '0;
            rd_count <= '0;
        end else if (srst) begin
            wr_count <= '0;
            rd_count <= '0;
        end else begin
            case ({wr_accept, wr_cpl})
                2'b10:   wr_count <= wr_count + 1'b1;
                2'b01:   wr_count <= wr_count - 1'b1;
                default: wr_count <= wr_count;
            endcase
            case ({rd_accept, rd_cpl})
                2'b10:   rd_count <= rd_count + 1'b1;
                2'b01:   rd_count <= rd_count - 1'b1;
                default: rd_count <= rd_count;
            endcase
        end
    end

    always_comb begin
        or_status.wr_pending = (wr_count != '0);
        or_status.rd_pending = (rd_count != '0);
        or_status.wr_full    = (wr_count == WR_MAX);
        or_status.rd_full    = (rd_count == RD_MAX);
    end

    // The fence controller must hold requests off at the limit
    a_wr_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        wr_accept |-> (wr_count != WR_MAX));
    a_rd_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        rd_accept |-> (rd_count != RD_MAX));

    // A completion needs an earlier accepted request
    a_wr_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        wr_cpl |-> (wr_count != '0));
    a_rd_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        rd_cpl |-> (rd_count != '0));

endmodule

`default_nettype wire

// ==== rtl/axi_fence_ctrl.sv ====
/* FENCE sequencer and request gating between the core and the AXI slave.
   Holds AW and AR off while draining or while a direction is full */

`timescale 1ns/1ps
`default_nettype none

module axi_fence_ctrl
    import axi_guard_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       aresetn,
    input  wire logic       srst,
    input  wire logic       fence,
    input  wire or_status_t or_status,
    input  wire axi_mst_t   core_mst,
    input  wire axi_slv_t   mem_slv,
    output axi_mst_t        mem_mst,
    output axi_slv_t        core_slv,
    output logic            fence_done
);

    fence_state_t state;
    fence_state_t state_nxt;
    logic         fencing;
    logic         block_wr;
    logic         block_rd;

    ////////////////////
    // Fence FSM
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // A fence outside IDLE is simply dropped
                if (fence) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (!or_status.wr_pending && !or_status.rd_pending) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
        end else if (srst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // One pulse, the single DONE cycle
    assign fence_done = (state == DONE);

    ////////////////////
    // Gating
    ////////////////////

    assign fencing  = (state == DRAIN) || (state == DONE);
    assign block_wr = fencing || or_status.wr_full;
    assign block_rd = fencing || or_status.rd_full;

    always_comb begin
        mem_mst.awvalid  = core_mst.awvalid & ~block_wr;
        mem_mst.arvalid  = core_mst.arvalid & ~block_rd;
        mem_mst.bready   = core_mst.bready;
        mem_mst.rready   = core_mst.rready;
        core_slv.awready = mem_slv.awready & ~block_wr;
        core_slv.arready = mem_slv.arready & ~block_rd;
        core_slv.bvalid  = mem_slv.bvalid;
        core_slv.rvalid  = mem_slv.rvalid;
    end

    // Drain must have emptied both counters in the tracker
    a_done_when_drained: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        $rose(fence_done) |-> !(or_status.wr_pending || or_status.rd_pending));

    // No new request may reach the slave while draining
    a_no_req_in_drain: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        (state == DRAIN) |=> !($rose(or_status.wr_pending) || $rose(or_status.rd_pending)));

endmodule

`default_nettype wire

// ==== rtl/axi_guard_top.sv ====
/* Outstanding-transaction guard for the core's AXI4 memory port.
   Sits between the core master and the slave, on handshake bits only */

`timescale 1ns/1ps
`default_nettype none

module axi_guard_top
    import axi_guard_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       aresetn,
    input  wire logic       srst,
    input  wire logic       fence,
    // Core side
    input  wire axi_mst_t   core_mst,
    output axi_slv_t        core_slv,
    // Slave side
    input  wire axi_slv_t   mem_slv,
    output axi_mst_t        mem_mst,
    // Status
    output logic            fence_done,
    output or_status_t      or_status
);

    ////////////////////
    // Counters
    ////////////////////

    // Sees the gated requests, so only real memory-side handshakes count
    axi_or_tracker axi_or_tracker_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .srst      (srst),
        .mem_mst   (mem_mst),
        .mem_slv   (mem_slv),
        .or_status (or_status)
    );

    ////////////////////
    // Fence and gating
    ////////////////////

    axi_fence_ctrl axi_fence_ctrl_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .srst       (srst),
        .fence      (fence),
        .or_status  (or_status),
        .core_mst   (core_mst),
        .mem_slv    (mem_slv),
        .mem_mst    (mem_mst),
        .core_slv   (core_slv),
        .fence_done (fence_done)
    );

endmodule

`default_nettype wire

// ==== sim/axi_guard_tb.sv ====
/* Testbench for the AXI4 guard that replays the stimulus file, one line per cycle.
   A reference model of the counters and the fence FSM predicts every output */

`timescale 1ns/1ps
`default_nettype none

`include "axi_guard_defs.svh"

module axi_guard_tb
    import axi_guard_pkg::*;
();

    localparam int MAX_LINES = 64;

    logic         aclk;
    logic         aresetn;
    logic         srst;
    logic         fence;
    axi_mst_t     core_mst;
    axi_slv_t     mem_slv;
    axi_slv_t     core_slv;
    axi_mst_t     mem_mst;
    logic         fence_done;
    or_status_t   or_status;

    // Bit 16 marks a slot the data file did not fill
    logic [16:0]  stim [0:MAX_LINES-1];
    int           n_lines;
    int           cur_line;
    int           cycles = 0;
    int           cycle_limit = 0;
    int           err_status;
    int           err_mst;
    int           err_slv;
    int           err_done;
    logic [31:0]  lfsr;

    // Reference model state
    int           wr_cnt;
    int           rd_cnt;
    fence_state_t model_state;

    axi_guard_top axi_guard_top_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .srst       (srst),
        .fence      (fence),
        .core_mst   (core_mst),
        .core_slv   (core_slv),
        .mem_slv    (mem_slv),
        .mem_mst    (mem_mst),
        .fence_done (fence_done),
        .or_status  (or_status)
    );

    always #20 aclk = ~aclk;

    ////////////////////
    // Helpers
    ////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_status(input or_status_t exp, input or_status_t act);
        if (act !== exp) begin
            err_status++;
            $display("[FAIL] line %0d or_status exp %h got %h (model %s)",
                     cur_line, exp, act, model_state.name());
        end
    endtask

    task automatic check_mst(input string name, input axi_mst_t exp, input axi_mst_t act);
        if (act !== exp) begin
            err_mst++;
            $display("[FAIL] line %0d %s exp %h got %h", cur_line, name, exp, act);
        end
    endtask

    task automatic check_slv(input string name, input axi_slv_t exp, input axi_slv_t act);
        if (act !== exp) begin
            err_slv++;
            $display("[FAIL] line %0d %s exp %h got %h", cur_line, name, exp, act);
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_done++;
            $display("[FAIL] line %0d %s exp %h got %h (model %s)",
                     cur_line, name, exp, act, model_state.name());
        end
    endtask

    // Run limit
    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Error: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////
    // Stimulus and model
    ////////////////////

    initial begin
        logic [15:0] word;
        axi_mst_t    exp_mst;
        axi_slv_t    exp_slv;
        or_status_t  exp_st;
        logic        blk_wr;
        logic        blk_rd;
        int          total;

        aclk        = 1'b0;
        aresetn     = 1'b0;
        srst        = 1'b0;
        fence       = 1'b0;
        core_mst    = '0;
        mem_slv     = '0;
        lfsr        = 32'h5865;
        wr_cnt      = 0;
        rd_cnt      = 0;
        model_state = IDLE;
        err_status  = 0;
        err_mst     = 0;
        err_slv     = 0;
        err_done    = 0;
        for (int i = 0; i < MAX_LINES; i++) begin
            stim[i] = {1'b1, 16'(i)};
        end
        $readmemh("sim/axi_guard_testdata.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && !stim[n_lines][16]) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            $display("Error: no stimulus lines could be read");
            $display("Test FAILED");
            $finish;
        end else begin
            cycle_limit = 4 * n_lines + 100;
            repeat (8) @(posedge aclk);
            @(negedge aclk);
            aresetn = 1'b1;
            for (int ln = 0; ln < n_lines; ln++) begin
                @(negedge aclk);
                cur_line = ln;
                word     = stim[ln][15:0];
                core_mst = word[15:12];
                mem_slv  = word[11:8];
                if (word[6]) begin
                    lfsr = lfsr_next(lfsr);
                    mem_slv.awready = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                    mem_slv.arready = lfsr[0];
                end
                // Slave answers only requests it has taken
                mem_slv.bvalid = mem_slv.bvalid & (wr_cnt != 0);
                mem_slv.rvalid = mem_slv.rvalid & (rd_cnt != 0);
                srst  = word[5];
                fence = word[4];
                #1;
                exp_st.wr_pending = (wr_cnt != 0);
                exp_st.rd_pending = (rd_cnt != 0);
                exp_st.wr_full    = (wr_cnt == `AXI_GUARD_MAX_WR_OR);
                exp_st.rd_full    = (rd_cnt == `AXI_GUARD_MAX_RD_OR);
                blk_wr = (model_state != IDLE) || exp_st.wr_full;
                blk_rd = (model_state != IDLE) || exp_st.rd_full;
                exp_mst.awvalid  = core_mst.awvalid & ~blk_wr;
                exp_mst.arvalid  = core_mst.arvalid & ~blk_rd;
                exp_mst.bready   = core_mst.bready;
                exp_mst.rready   = core_mst.rready;
                exp_slv.awready  = mem_slv.awready & ~blk_wr;
                exp_slv.arready  = mem_slv.arready & ~blk_rd;
                exp_slv.bvalid   = mem_slv.bvalid;
                exp_slv.rvalid   = mem_slv.rvalid;
                check_status(exp_st, or_status);
                check_mst("mem_mst", exp_mst, mem_mst);
                check_slv("core_slv", exp_slv, core_slv);
                check_done("fence_done", model_state == DONE, fence_done);
                if (word[1]) begin
                    check_done("fence_done vs file", word[0], fence_done);
                end
                // Advance the model over the coming edge
                if (srst) begin
                    wr_cnt      = 0;
                    rd_cnt      = 0;
                    model_state = IDLE;
                end else begin
                    wr_cnt += int'(exp_mst.awvalid & mem_slv.awready);
                    wr_cnt -= int'(mem_slv.bvalid & core_mst.bready);
                    rd_cnt += int'(exp_mst.arvalid & mem_slv.arready);
                    rd_cnt -= int'(mem_slv.rvalid & core_mst.rready);
                    case (model_state)
                        IDLE:    model_state = fence ? DRAIN : IDLE;
                        DRAIN:   model_state = (exp_st.wr_pending || exp_st.rd_pending) ?
                                               DRAIN : DONE;
                        default: model_state = IDLE;
                    endcase
                end
            end
            @(negedge aclk);
            total = err_status + err_mst + err_slv + err_done;
            $display("Errors: %0d (or_status %0d, mem_mst %0d, core_slv %0d, done %0d)",
                     total, err_status, err_mst, err_slv, err_done);
            if (total == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/axi_guard_testdata.txt ====
// One hex word per cycle: core_mst | mem_slv | ctrl {0,rnd,srst,fence} | exp {0,0,chk,done}
// core_mst bits awvalid arvalid bready rready; mem_slv bits awready arready bvalid rvalid
0012 // fence with nothing outstanding
0002
0003 // done two cycles after the pulse
0002
CC02 // one write and one read accepted
FF02 // accept and completion together
0012 // fence with requests outstanding
FF02 // requests held off, both complete
0002
0003
0002
8802 // fill the write direction
8802
8802
8802
8802
8802
8802
8802
8802 // full, request held off
AA02 // completion frees a slot
8802
0012 // fence while full
0022 // srst in DRAIN
CC02 // traffic passes again
F342 // random awready and arready
C042
C042
F342
C042
F342

// ==== axi_guard_top.f ====
+incdir+rtl
rtl/axi_guard_pkg.sv
rtl/axi_or_tracker.sv
rtl/axi_fence_ctrl.sv
rtl/axi_guard_top.sv
sim/axi_guard_tb.sv

// ==== Makefile ====
# Verilator build and run of the AXI4 guard testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= axi_guard_tb
FILELIST  ?= axi_guard_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
